// File: hw/bitRateGen.sv
`timescale 1ns/10ps

module bitRateGen #(
    parameter int rateDivide = stcPkg::defaultRateDivide
) (
    input  logic clk,
    input  logic reset,
    output logic bitStrobe
);

    // a ratio of 1 still needs a one-bit counter
    localparam int countWidth = (rateDivide > 1) ? $clog2(rateDivide) : 1;

    logic [countWidth-1:0] count;

    // down-counter, strobe is registered so the first one lands
    // rateDivide cycles after reset goes away
    always_ff @(posedge clk) begin
        if (reset) begin
            count     <= countWidth'(rateDivide - 1);
            bitStrobe <= 1'b0;
        end
        else begin
            if (count == '0) begin
                count     <= countWidth'(rateDivide - 1);
                bitStrobe <= 1'b1;
            end
            else begin
                count     <= count - countWidth'(1);
                bitStrobe <= 1'b0;
            end
        end
    end

endmodule

// File: hw/stcBitIf.sv
`timescale 1ns/10ps

interface stcBitIf;

    // coded antenna bits, valid whenever bitStrobe is high
    logic stcBit0;
    logic stcBit1;

    // high for the whole pilot
    logic frameSync;

    // bit-rate enable, forwarded so the precoder stays in step
    logic bitStrobe;

    modport source (
        output stcBit0,
        output stcBit1,
        output frameSync,
        output bitStrobe
    );

    modport sink (
        input stcBit0,
        input stcBit1,
        input frameSync,
        input bitStrobe
    );

endinterface

// File: hw/stcDiffEncoder.sv
`timescale 1ns/10ps

module stcDiffEncoder (
    input  logic  clk,
    input  logic  reset,
    stcBitIf.sink stcIn,
    output logic  txBit0,
    output logic  txBit1,
    output logic  txFrameSync,
    output logic  txStrobe
);

    logic restart;

    // txFrameSync holds the flag of the previous bit, so a low-to-high
    // step here marks the first pilot bit
    assign restart = stcIn.frameSync && !txFrameSync;

    always_ff @(posedge clk) begin
        if (reset) begin
            txBit0      <= 1'b0;
            txBit1      <= 1'b0;
            txFrameSync <= 1'b0;
            txStrobe    <= 1'b0;
        end
        else begin
            txStrobe <= stcIn.bitStrobe;
            if (stcIn.bitStrobe) begin
                txFrameSync <= stcIn.frameSync;
                if (restart) begin
                    // previous bit counts as zero at each pilot start
                    txBit0 <= stcIn.stcBit0;
                    txBit1 <= stcIn.stcBit1;
                end
                else begin
                    txBit0 <= stcIn.stcBit0 ^ txBit0;
                    txBit1 <= stcIn.stcBit1 ^ txBit1;
                end
            end
        end
    end

endmodule

// File: hw/stcFramer.sv
`timescale 1ns/10ps

module stcFramer #(
    parameter int payloadBits = stcPkg::defaultPayloadBits
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    bitStrobe,
    output logic    payloadReq,
    input  logic    payloadBit,
    stcBitIf.source stcOut
);

    // bit counter must hold the longer of the two phases
    localparam int countMax =
        (payloadBits > stcPkg::pilotBits) ? payloadBits : stcPkg::pilotBits;
    localparam int countWidth = $clog2(countMax);

    // coded form of an all-zero group, sent in the short block after reset
    localparam stcPkg::stcNibble idleCode0 = 4'b0010;
    localparam stcPkg::stcNibble idleCode1 = 4'b0001;

    stcPkg::stcState           state;
    logic [countWidth-1:0]     bitCount;
    logic [stcPkg::pilotBits-1:0] pilot0Sr;
    logic [stcPkg::pilotBits-1:0] pilot1Sr;
    stcPkg::stcNibble          payload0Sr;
    stcPkg::stcNibble          payload1Sr;
    logic [2:0]                collect;
    stcPkg::stcNibble          groupBits;
    stcPkg::stcNibble          pending;
    stcPkg::stcNibble          srcGroup;
    stcPkg::stcNibble          code0;
    stcPkg::stcNibble          code1;
    logic                      blockEnd;
    logic                      groupEnd;
    logic                      loadGroup;

    // ##############################
    // phase sequencer
    // ##############################

    assign blockEnd = (bitCount == '0);
    assign groupEnd = (bitCount[1:0] == 2'b00);

    always_ff @(posedge clk) begin
        if (reset) begin
            // short four-bit block first
            state    <= stcPkg::statePayload;
            bitCount <= countWidth'(3);
        end
        else if (bitStrobe) begin
            case (state)
                stcPkg::statePilot: begin
                    if (blockEnd) begin
                        state    <= stcPkg::statePayload;
                        bitCount <= countWidth'(payloadBits - 1);
                    end
                    else begin
                        bitCount <= bitCount - countWidth'(1);
                    end
                end
                stcPkg::statePayload: begin
                    if (blockEnd) begin
                        state    <= stcPkg::statePilot;
                        bitCount <= countWidth'(stcPkg::pilotBits - 1);
                    end
                    else begin
                        bitCount <= bitCount - countWidth'(1);
                    end
                end
            endcase
        end
    end

    // ##############################
    // payload fetch and coding
    // ##############################

    // one request per payload bit, answered in the same cycle
    assign payloadReq = bitStrobe && (state == stcPkg::statePayload);

    // b0 arrived first and sits in bit 0
    assign groupBits = {payloadBit, collect};

    // after a pilot the group held across it goes out first
    assign srcGroup = (state == stcPkg::statePilot) ? pending : groupBits;
    assign code0    = {srcGroup[0], srcGroup[1], ~srcGroup[2], srcGroup[3]};
    assign code1    = {srcGroup[2], srcGroup[3], srcGroup[0], ~srcGroup[1]};

    assign loadGroup = ((state == stcPkg::statePilot) && blockEnd) ||
                       ((state == stcPkg::statePayload) && groupEnd && !blockEnd);

    always_ff @(posedge clk) begin
        if (bitStrobe) begin
            if (state == stcPkg::statePayload) begin
                collect <= groupBits[3:1];
            end
            if ((state == stcPkg::statePayload) && blockEnd) begin
                // last group of the block waits out the pilot
                pending  <= groupBits;
                pilot0Sr <= stcPkg::pilot0Word;
                pilot1Sr <= stcPkg::pilot1Word;
            end
            else if (state == stcPkg::statePilot) begin
                pilot0Sr <= {pilot0Sr[stcPkg::pilotBits-2:0], 1'b0};
                pilot1Sr <= {pilot1Sr[stcPkg::pilotBits-2:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            payload0Sr <= idleCode0;
            payload1Sr <= idleCode1;
        end
        else if (bitStrobe) begin
            if (loadGroup) begin
                payload0Sr <= code0;
                payload1Sr <= code1;
            end
            else if (state == stcPkg::statePayload) begin
                payload0Sr <= {payload0Sr[2:0], 1'b0};
                payload1Sr <= {payload1Sr[2:0], 1'b0};
            end
        end
    end

    // ##############################
    // output select
    // ##############################

    assign stcOut.stcBit0 = (state == stcPkg::statePilot) ?
                            pilot0Sr[stcPkg::pilotBits-1] : payload0Sr[3];
    assign stcOut.stcBit1 = (state == stcPkg::statePilot) ?
                            pilot1Sr[stcPkg::pilotBits-1] : payload1Sr[3];
    assign stcOut.frameSync = (state == stcPkg::statePilot);
    assign stcOut.bitStrobe = bitStrobe;

endmodule

// File: hw/stcPkg.sv
package stcPkg;

    // ##############################
    // frame geometry
    // ##############################

    // pilot length per frame, both antennas carry one word each
    localparam int pilotBits = 128;

    // default payload block between pilots, must be a multiple of 4
    localparam int defaultPayloadBits = 3200;

    // clk cycles per transmitted bit
    localparam int defaultRateDivide = 4;

    // ##############################
    // pilot sequences
    // ##############################

    // sent msb first on antenna 0
    localparam logic [pilotBits-1:0] pilot0Word =
        128'ha88d_9ad4_dc40_4947_e292_023b_2b59_b115;

    // sent msb first on antenna 1
    localparam logic [pilotBits-1:0] pilot1Word =
        128'he3c7_7761_f070_36be_7d6c_0e0f_86ee_e3c7;

    // ##############################
    // types
    // ##############################

    // one space-time group, raw or coded
    typedef logic [3:0] stcNibble;

    // framer phase
    typedef enum logic {
        statePilot   = 1'b0,
        statePayload = 1'b1
    } stcState;

endpackage

// File: hw/stcTx.sv
`timescale 1ns/10ps

module stcTx #(
    parameter int payloadBits = stcPkg::defaultPayloadBits,
    parameter int rateDivide  = stcPkg::defaultRateDivide
) (
    input  logic clk,
    input  logic reset,
    input  logic payloadBit,
    output logic payloadReq,
    output logic txBit0,
    output logic txBit1,
    output logic txFrameSync,
    output logic txStrobe
);

    logic bitStrobe;

    // framer to precoder
    stcBitIf stcLink ();

    // ##############################
    // bit clock enable
    // ##############################

    bitRateGen #(
        .rateDivide (rateDivide)
    ) rateGen (
        .clk       (clk),
        .reset     (reset),
        .bitStrobe (bitStrobe)
    );

    // ##############################
    // framing and coding
    // ##############################

    stcFramer #(
        .payloadBits (payloadBits)
    ) framer (
        .clk        (clk),
        .reset      (reset),
        .bitStrobe  (bitStrobe),
        .payloadReq (payloadReq),
        .payloadBit (payloadBit),
        .stcOut     (stcLink.source)
    );

    // per-antenna differential precoding
    stcDiffEncoder diffEncoder (
        .clk         (clk),
        .reset       (reset),
        .stcIn       (stcLink.sink),
        .txBit0      (txBit0),
        .txBit1      (txBit1),
        .txFrameSync (txFrameSync),
        .txStrobe    (txStrobe)
    );

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module stcTxTb -f verilog.f -o stcTxSim &&
./obj_dir/stcTxSim || { echo "simulation failed"; exit 1; }

// File: testbench/stcTxProps.sv
`timescale 1ns/10ps

module stcTxProps (
    input logic clk,
    input logic reset,
    input logic payloadReq,
    input logic txStrobe,
    input logic txFrameSync
);

    // output strobe is a single clk wide
    strobeWidth: assert property (@(posedge clk) disable iff (reset)
        txStrobe |=> !txStrobe)
        else $error("txStrobe wider than one cycle");

    // a fetched payload bit never leaves flagged as a pilot bit
    noReqInPilot: assert property (@(posedge clk) disable iff (reset)
        payloadReq |=> !txFrameSync)
        else $error("payloadReq fell on a pilot bit");

    // frame flag only moves together with a bit
    syncOnStrobe: assert property (@(posedge clk) disable iff (reset)
        !$stable(txFrameSync) |-> txStrobe)
        else $error("txFrameSync changed outside a strobe cycle");

endmodule

// File: testbench/stcTxStimulus.txt
# payload nibble, expected antenna-0 coded nibble, expected antenna-1 coded nibble
# hex, the first payload bit of a group is the nibble msb
a 8 b
3 1 d
f d e
0 2 1
5 7 4
c e 2
9 b 7
6 4 8
1 3 5
e c a
7 5 c
8 a 3
b 9 f
4 6 0
d f 6
2 0 9
5 7 4

// File: testbench/stcTxTb.sv
`timescale 1ns/10ps

module stcTxTb;

    localparam int payloadBits  = 64;
    localparam int rateDivide   = 4;
    localparam int pilotBits    = stcPkg::pilotBits;
    localparam int frameBits    = pilotBits + payloadBits;
    // short block, then four pilots with three payload blocks between them
    localparam int totalStrobes = 4 + 4 * pilotBits + 3 * payloadBits;
    localparam longint timeoutNs = longint'(totalStrobes + 32) * rateDivide * 100 + 5000;
    localparam int maxNibbles   = 64;

    logic clk;
    logic reset;
    logic payloadBit;
    logic payloadReq;
    logic txBit0;
    logic txBit1;
    logic txFrameSync;
    logic txStrobe;

    stcPkg::stcNibble stimNibble [maxNibbles];
    stcPkg::stcNibble expCode0 [maxNibbles];
    stcPkg::stcNibble expCode1 [maxNibbles];
    stcPkg::stcNibble group0;
    stcPkg::stcNibble group1;
    stcPkg::stcState  phase;
    int nibbleCount;
    int reqCount;
    int lastReqSnapshot;
    int strobeCount;
    int gapCycles;
    int pilotStarts;
    int pilotIndex;
    int groupBitCount;
    int groupIndex;
    logic prev0;
    logic prev1;
    logic lastFs;
    logic coded0;
    logic coded1;

    stcTx #(
        .payloadBits (payloadBits),
        .rateDivide  (rateDivide)
    ) uut (
        .clk         (clk),
        .reset       (reset),
        .payloadBit  (payloadBit),
        .payloadReq  (payloadReq),
        .txBit0      (txBit0),
        .txBit1      (txBit1),
        .txFrameSync (txFrameSync),
        .txStrobe    (txStrobe)
    );

    bind stcTx stcTxProps props (
        .clk         (clk),
        .reset       (reset),
        .payloadReq  (payloadReq),
        .txStrobe    (txStrobe),
        .txFrameSync (txFrameSync)
    );

    always #50 clk = ~clk;

    // ##############################
    // compare tasks
    // ##############################

    task automatic reportMismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        $display("** FAIL **");
        $fatal(1, "mismatch");
    endtask

    task automatic checkBit(input logic actual, input logic expected, input string what);
        if (actual !== expected)
            reportMismatch($sformatf("%s is %b, expected %b", what, actual, expected));
    endtask

    task automatic checkNibble(input stcPkg::stcNibble actual,
                               input stcPkg::stcNibble expected, input string what);
        if (actual !== expected)
            reportMismatch($sformatf("%s is %h, expected %h", what, actual, expected));
    endtask

    task automatic checkState(input stcPkg::stcState actual,
                              input stcPkg::stcState expected, input string what);
        if (actual !== expected)
            reportMismatch($sformatf("%s is %s, expected %s", what, actual.name(),
                                     expected.name()));
    endtask

    task automatic checkCount(input int actual, input int expected, input string what);
        if (actual != expected)
            reportMismatch($sformatf("%s is %0d, expected %0d", what, actual, expected));
    endtask

    task automatic checkOutputsLow(input string when);
        checkBit(payloadReq, 1'b0, {"payloadReq ", when});
        checkBit(txStrobe, 1'b0, {"txStrobe ", when});
        checkBit(txFrameSync, 1'b0, {"txFrameSync ", when});
        checkBit(txBit0, 1'b0, {"txBit0 ", when});
        checkBit(txBit1, 1'b0, {"txBit1 ", when});
    endtask

    // ##############################
    // stimulus and reference
    // ##############################

    task automatic readStimulus();
        int fd;
        string line;
        stcPkg::stcNibble n;
        stcPkg::stcNibble c0;
        stcPkg::stcNibble c1;
        fd = $fopen("testbench/stcTxStimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            $display("** FAIL **");
            $fatal(1, "no stimulus");
        end
        while (!$feof(fd) && nibbleCount < maxNibbles) begin
            line = "";
            if ($fgets(line, fd) != 0 && line.len() > 0 && line[0] != "#") begin
                if ($sscanf(line, "%h %h %h", n, c0, c1) == 3) begin
                    stimNibble[nibbleCount] = n;
                    expCode0[nibbleCount]   = c0;
                    expCode1[nibbleCount]   = c1;
                    nibbleCount++;
                end
            end
        end
        $fclose(fd);
    endtask

    // zeros once the file runs out
    function automatic logic nextPayloadBit(input int idx);
        if (idx / 4 >= nibbleCount)
            return 1'b0;
        return stimNibble[idx / 4][3 - idx % 4];
    endfunction

    function automatic stcPkg::stcState expectedPhase(input int k);
        if (k < 4)
            return stcPkg::statePayload;
        if (((k - 4) % frameBits) < pilotBits)
            return stcPkg::statePilot;
        return stcPkg::statePayload;
    endfunction

    // group 0 and groups past the file carry all-zero data
    task automatic checkGroup();
        if (groupIndex == 0 || groupIndex - 1 >= nibbleCount) begin
            checkNibble(group0, 4'b0010, $sformatf("antenna 0 group %0d", groupIndex));
            checkNibble(group1, 4'b0001, $sformatf("antenna 1 group %0d", groupIndex));
        end
        else begin
            checkNibble(group0, expCode0[groupIndex-1],
                        $sformatf("antenna 0 group %0d", groupIndex));
            checkNibble(group1, expCode1[groupIndex-1],
                        $sformatf("antenna 1 group %0d", groupIndex));
        end
    endtask

    // answer each request in its own cycle
    always @(posedge clk) begin
        #1;
        if (!reset && payloadReq) begin
            payloadBit = nextPayloadBit(reqCount);
            reqCount++;
        end
    end

    // ##############################
    // output monitor
    // ##############################

    always @(negedge clk) begin
        if (!reset && strobeCount < totalStrobes) begin
            if (strobeCount > 0)
                gapCycles++;
            if (txStrobe) begin
                if (strobeCount > 0)
                    checkCount(gapCycles, rateDivide, "strobe spacing");
                gapCycles = 0;
                phase = txFrameSync ? stcPkg::statePilot : stcPkg::statePayload;
                checkState(phase, expectedPhase(strobeCount), "phase");
                // undo the precoding, restart at each pilot
                if (txFrameSync && !lastFs) begin
                    coded0 = txBit0;
                    coded1 = txBit1;
                    pilotStarts++;
                    pilotIndex = 0;
                    checkCount(reqCount - lastReqSnapshot,
                               (pilotStarts == 1) ? 4 : payloadBits,
                               "payload requests before pilot");
                    lastReqSnapshot = reqCount;
                end
                else begin
                    coded0 = txBit0 ^ prev0;
                    coded1 = txBit1 ^ prev1;
                end
                prev0  = txBit0;
                prev1  = txBit1;
                lastFs = txFrameSync;
                if (txFrameSync) begin
                    checkBit(coded0, stcPkg::pilot0Word[pilotBits-1-pilotIndex], "pilot 0 bit");
                    checkBit(coded1, stcPkg::pilot1Word[pilotBits-1-pilotIndex], "pilot 1 bit");
                    pilotIndex++;
                end
                else begin
                    group0 = {group0[2:0], coded0};
                    group1 = {group1[2:0], coded1};
                    groupBitCount++;
                    if (groupBitCount == 4) begin
                        checkGroup();
                        groupBitCount = 0;
                        groupIndex++;
                    end
                end
                strobeCount++;
            end
        end
    end

    initial begin
        #(timeoutNs);
        $display("run timed out before all checks were done");
        $display("** FAIL **");
        $fatal(1, "timeout");
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        payloadBit = 1'b0;
        nibbleCount = 0;
        reqCount = 0;
        lastReqSnapshot = 0;
        strobeCount = 0;
        gapCycles = 0;
        pilotStarts = 0;
        pilotIndex = 0;
        groupBitCount = 0;
        groupIndex = 0;
        prev0 = 1'b0;
        prev1 = 1'b0;
        lastFs = 1'b0;
        group0 = '0;
        group1 = '0;
        readStimulus();
        repeat (5) begin
            @(posedge clk);
            @(negedge clk);
            checkOutputsLow("during reset");
        end
        @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        checkOutputsLow("after reset");
        wait (strobeCount == totalStrobes);
        checkCount(pilotStarts, 4, "pilot count");
        $display("** PASS **");
        $finish;
    end

endmodule

// File: verilog.f
hw/stcPkg.sv
hw/stcBitIf.sv
hw/bitRateGen.sv
hw/stcFramer.sv
hw/stcDiffEncoder.sv
hw/stcTx.sv
testbench/stcTxProps.sv
testbench/stcTxTb.sv
